// File: rtl/mcoc_cfg.svh
`ifndef MCOC_CFG_SVH
`define MCOC_CFG_SVH

`define MCOC_DW		16	// Bus data width
`define MCOC_AW		16	// Bus address width
`define MCOC_IO_PAGE	8'hFF	// High address byte of I/O page

`define MCOC_BLK_SYSC	4'h0	// Block numbers in adr[7:4]
`define MCOC_BLK_PORT	4'h1
`define MCOC_BLK_TIM0	4'h2
`define MCOC_BLK_TIM1	4'h3
`define MCOC_BLK_INTC	4'h4

`define MCOC_IDCODE	16'h1150	// Chip ID
`define MCOC_VERSNO	16'h0148	// Version
`define MCOC_FCPU_KHZ	16'd24000	// Clock rate in kHz
`define MCOC_SYTM_DIV	24	// Clocks per system tick

`define MCOC_PORT_W	8	// Port width
`define MCOC_PORT_ENB_RST	8'h00	// All pins hi-Z after reset
`define MCOC_INT_N	8	// Interrupt factors

`define MCOC_SYSC_IDCODE	4'h0	// System control offsets
`define MCOC_SYSC_VERSNO	4'h2
`define MCOC_SYSC_FCPU	4'h4
`define MCOC_SYSC_BOOTMD	4'h6
`define MCOC_SYSC_TICK	4'h8

`define MCOC_PORT_OUT	4'h0	// Port offsets
`define MCOC_PORT_ENB	4'h2
`define MCOC_PORT_SEL	4'h4
`define MCOC_PORT_INP	4'h6

`define MCOC_TIM_CTRL	4'h0	// Timer offsets, ctrl bit 0 is run
`define MCOC_TIM_PERIOD	4'h2
`define MCOC_TIM_CMPA	4'h4
`define MCOC_TIM_CMPB	4'h6
`define MCOC_TIM_CNT	4'h8

`define MCOC_INTC_FLAG	4'h0	// Interrupt controller offsets
`define MCOC_INTC_ENB	4'h2
`define MCOC_INTC_VEC	4'h4

`endif

// File: rtl/mcoc_pkg.sv
`default_nettype none
`include "mcoc_cfg.svh"

package mcoc_pkg;

	// Request from bus master, one cycle per access
	typedef struct packed {
		logic rd;	// Read strobe
		logic wr;	// Write strobe
		logic [`MCOC_AW-1:0] adr;	// Byte address
		logic [`MCOC_DW-1:0] wdat;	// Write data
	} bus_req_t;

	// One-hot chip selects
	typedef struct packed {
		logic sysc;
		logic port;
		logic tim0;
		logic tim1;
		logic intc;
	} bus_sel_t;

	// Timer event pulses to interrupt controller
	typedef struct packed {
		logic ovf;	// Count wrapped
		logic cma;	// Count hit compare A
		logic cmb;	// Count hit compare B
	} tim_evt_t;

endpackage

`default_nettype wire

// File: rtl/mcoc_busdec.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_busdec
	import mcoc_pkg::*;
(
	input wire bus_req_t bus_i,
	output bus_sel_t sel_o
);
	logic io_page;
	logic [3:0] blk;

	assign io_page = bus_i.adr[`MCOC_AW-1 -: 8] == `MCOC_IO_PAGE;	// Top byte
	assign blk = bus_i.adr[7:4];	// Block number

	always_comb begin
		sel_o = '0;
		if (io_page) begin
			sel_o.sysc = blk == `MCOC_BLK_SYSC;
			sel_o.port = blk == `MCOC_BLK_PORT;
			sel_o.tim0 = blk == `MCOC_BLK_TIM0;
			sel_o.tim1 = blk == `MCOC_BLK_TIM1;
			sel_o.intc = blk == `MCOC_BLK_INTC;
		end
	end

endmodule

`default_nettype wire

// File: rtl/mcoc_sysc.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_sysc
	import mcoc_pkg::*;
(
	input wire clk,
	input wire arst_n_i,
	input wire bootr_n_i,
	input wire bus_req_t bus_i,
	input wire sel_i,
	output logic rst_n_o,
	output logic [`MCOC_DW-1:0] rdat_o
);
	localparam int DW = `MCOC_DW;
	localparam int DIV = `MCOC_SYTM_DIV;
	localparam int PW = $clog2(DIV);

	logic [1:0] rst_sync;	// Release synchronizer
	logic bootmd;
	logic [PW-1:0] presc;	// Tick prescaler
	logic [DW-1:0] tick;
	logic [DW-1:0] rd_mux;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rst_sync <= 2'b00;
			bootmd <= 1'b0;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
			if (!rst_sync[1])
				bootmd <= ~bootr_n_i;	// Last sample lands on release edge
		end
	end

	assign rst_n_o = rst_sync[1];

	always_ff @(posedge clk or negedge rst_n_o) begin
		if (!rst_n_o) begin
			presc <= '0;
			tick <= '0;
		end else if (presc == PW'(DIV - 1)) begin
			presc <= '0;
			tick <= tick + 1'b1;	// One tick per DIV clocks
		end else begin
			presc <= presc + 1'b1;
		end
	end

	always_comb begin
		case (bus_i.adr[3:0])
			`MCOC_SYSC_IDCODE: rd_mux = `MCOC_IDCODE;
			`MCOC_SYSC_VERSNO: rd_mux = `MCOC_VERSNO;
			`MCOC_SYSC_FCPU: rd_mux = `MCOC_FCPU_KHZ;
			`MCOC_SYSC_BOOTMD: rd_mux = DW'(bootmd);
			`MCOC_SYSC_TICK: rd_mux = tick;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_o) begin
		if (!rst_n_o)
			rdat_o <= '0;
		else
			rdat_o <= (sel_i && bus_i.rd) ? rd_mux : '0;	// Zero unless read
	end

endmodule

`default_nettype wire

// File: rtl/mcoc_port.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_port
	import mcoc_pkg::*;
(
	input wire clk,
	input wire rst_n_i,
	input wire bus_req_t bus_i,
	input wire sel_i,
	input wire [2*`MCOC_PORT_W-1:0] pins_i,
	output logic [`MCOC_PORT_W-1:0] out_o,
	output logic [`MCOC_PORT_W-1:0] enb_o,
	output logic [`MCOC_DW-1:0] rdat_o
);
	localparam int DW = `MCOC_DW;
	localparam int PW = `MCOC_PORT_W;

	logic [PW-1:0] psel;	// 1 picks own pin, 0 picks pin n+8
	logic [2*PW-1:0] pin_s1;
	logic [2*PW-1:0] pin_s2;
	logic [PW-1:0] inp;
	logic wr_en;
	logic [DW-1:0] rd_mux;

	assign wr_en = sel_i & bus_i.wr;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_o <= '0;
			enb_o <= `MCOC_PORT_ENB_RST;
			psel <= '0;
		end else if (wr_en) begin
			case (bus_i.adr[3:0])
				`MCOC_PORT_OUT: out_o <= bus_i.wdat[PW-1:0];
				`MCOC_PORT_ENB: enb_o <= bus_i.wdat[PW-1:0];
				`MCOC_PORT_SEL: psel <= bus_i.wdat[PW-1:0];
				default: ;
			endcase
		end
	end

	// Two-flop pin synchronizer
	always_ff @(posedge clk) begin
		pin_s1 <= pins_i;
		pin_s2 <= pin_s1;
	end

	assign inp = (psel & pin_s2[PW-1:0]) | (~psel & pin_s2[2*PW-1:PW]);	// Per-bit mux

	always_comb begin
		case (bus_i.adr[3:0])
			`MCOC_PORT_OUT: rd_mux = DW'(out_o);
			`MCOC_PORT_ENB: rd_mux = DW'(enb_o);
			`MCOC_PORT_SEL: rd_mux = DW'(psel);
			`MCOC_PORT_INP: rd_mux = DW'(inp);
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			rdat_o <= '0;
		else
			rdat_o <= (sel_i && bus_i.rd) ? rd_mux : '0;
	end

endmodule

`default_nettype wire

// File: rtl/mcoc_timer.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_timer
	import mcoc_pkg::*;
(
	input wire clk,
	input wire rst_n_i,
	input wire bus_req_t bus_i,
	input wire sel_i,
	output logic pwma_o,
	output logic pwmb_o,
	output tim_evt_t evt_o,
	output logic [`MCOC_DW-1:0] rdat_o
);
	localparam int DW = `MCOC_DW;

	logic run;	// Ctrl bit 0
	logic [DW-1:0] period;	// Last count before wrap
	logic [DW-1:0] cmpa;
	logic [DW-1:0] cmpb;
	logic [DW-1:0] cnt;
	logic wr_en;
	logic wrap;
	logic [DW-1:0] rd_mux;

	assign wr_en = sel_i & bus_i.wr;
	assign wrap = cnt == period;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			run <= 1'b0;
			period <= '0;
			cmpa <= '0;	// Keeps PWM low out of reset
			cmpb <= '0;
			cnt <= '0;
		end else begin
			if (run)
				cnt <= wrap ? '0 : cnt + 1'b1;	// Period+1 states
			if (wr_en) begin
				case (bus_i.adr[3:0])
					`MCOC_TIM_CTRL: run <= bus_i.wdat[0];
					`MCOC_TIM_PERIOD: period <= bus_i.wdat;
					`MCOC_TIM_CMPA: cmpa <= bus_i.wdat;
					`MCOC_TIM_CMPB: cmpb <= bus_i.wdat;
					`MCOC_TIM_CNT: cnt <= bus_i.wdat;	// Bus load wins over count
					default: ;
				endcase
			end
		end
	end

	assign pwma_o = cnt < cmpa;	// High for cmpa cycles per period
	assign pwmb_o = cnt < cmpb;

	// Single-cycle pulses while running
	assign evt_o.ovf = run & wrap;
	assign evt_o.cma = run & (cnt == cmpa);
	assign evt_o.cmb = run & (cnt == cmpb);

	always_comb begin
		case (bus_i.adr[3:0])
			`MCOC_TIM_CTRL: rd_mux = DW'(run);
			`MCOC_TIM_PERIOD: rd_mux = period;
			`MCOC_TIM_CMPA: rd_mux = cmpa;
			`MCOC_TIM_CMPB: rd_mux = cmpb;
			`MCOC_TIM_CNT: rd_mux = cnt;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			rdat_o <= '0;
		else
			rdat_o <= (sel_i && bus_i.rd) ? rd_mux : '0;
	end

endmodule

`default_nettype wire

// File: rtl/mcoc_intc.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_intc
	import mcoc_pkg::*;
(
	input wire clk,
	input wire rst_n_i,
	input wire bus_req_t bus_i,
	input wire sel_i,
	input wire int0_i,
	input wire int1_i,
	input wire tim_evt_t tim0_evt_i,
	input wire tim_evt_t tim1_evt_i,
	output logic irq_o,
	output logic [`MCOC_DW-1:0] rdat_o
);
	localparam int DW = `MCOC_DW;
	localparam int N = `MCOC_INT_N;

	logic [2:0] int0_s;	// Two sync stages plus edge history
	logic [2:0] int1_s;
	logic wr_en;
	logic [N-1:0] fct;
	logic [N-1:0] clr;
	logic [N-1:0] flag;
	logic [N-1:0] enb;
	logic [N-1:0] act;	// Enabled and pending
	logic [7:0] vec;
	logic [DW-1:0] rd_mux;

	assign wr_en = sel_i & bus_i.wr;

	assign fct = {tim1_evt_i.cmb, tim1_evt_i.cma, tim1_evt_i.ovf,
		tim0_evt_i.cmb, tim0_evt_i.cma, tim0_evt_i.ovf,
		int1_s[1] & ~int1_s[2], int0_s[1] & ~int0_s[2]};	// Bit 0 upward

	assign clr = (wr_en && bus_i.adr[3:0] == `MCOC_INTC_FLAG) ? bus_i.wdat[N-1:0] : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			int0_s <= '0;
			int1_s <= '0;
			flag <= '0;
			enb <= '0;
		end else begin
			int0_s <= {int0_s[1:0], int0_i};
			int1_s <= {int1_s[1:0], int1_i};
			flag <= (flag & ~clr) | fct;	// New event beats clear
			if (wr_en && bus_i.adr[3:0] == `MCOC_INTC_ENB)
				enb <= bus_i.wdat[N-1:0];
		end
	end

	assign act = flag & enb;
	assign irq_o = |act;

	// Lowest pending index, FF when idle
	always_comb begin
		vec = 8'hFF;
		for (int i = N - 1; i >= 0; i--) begin
			if (act[i])
				vec = 8'(i);
		end
	end

	always_comb begin
		case (bus_i.adr[3:0])
			`MCOC_INTC_FLAG: rd_mux = DW'(flag);
			`MCOC_INTC_ENB: rd_mux = DW'(enb);
			`MCOC_INTC_VEC: rd_mux = DW'(vec);
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			rdat_o <= '0;
		else
			rdat_o <= (sel_i && bus_i.rd) ? rd_mux : '0;
	end

endmodule

`default_nettype wire

// File: rtl/mcoc_periph.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module mcoc_periph
	import mcoc_pkg::*;
(
	input wire clk,
	input wire arst_n_i,
	input wire bootr_n_i,
	input wire bus_req_t bus_i,
	output logic [`MCOC_DW-1:0] rdat_o,
	input wire intc_int0_i,
	input wire intc_int1_i,
	inout wire [2*`MCOC_PORT_W-1:0] port_io,	// Upper byte input only
	output logic tim0_pwma_o,
	output logic tim0_pwmb_o,
	output logic tim1_pwma_o,
	output logic tim1_pwmb_o,
	output logic irq_o
);
	localparam int DW = `MCOC_DW;
	localparam int PW = `MCOC_PORT_W;

	logic rst_n;	// Synchronized reset
	bus_sel_t sel;
	logic [PW-1:0] port_out;
	logic [PW-1:0] port_enb;
	tim_evt_t tim0_evt;
	tim_evt_t tim1_evt;
	logic [DW-1:0] rdat_sysc;
	logic [DW-1:0] rdat_port;
	logic [DW-1:0] rdat_tim0;
	logic [DW-1:0] rdat_tim1;
	logic [DW-1:0] rdat_intc;

	mcoc_sysc sysc (.clk(clk), .arst_n_i(arst_n_i), .bootr_n_i(bootr_n_i),
		.bus_i(bus_i), .sel_i(sel.sysc), .rst_n_o(rst_n), .rdat_o(rdat_sysc));

	mcoc_busdec busdec (.bus_i(bus_i), .sel_o(sel));

	mcoc_port port (.clk(clk), .rst_n_i(rst_n), .bus_i(bus_i), .sel_i(sel.port),
		.pins_i(port_io), .out_o(port_out), .enb_o(port_enb), .rdat_o(rdat_port));

	mcoc_timer tim0 (.clk(clk), .rst_n_i(rst_n), .bus_i(bus_i), .sel_i(sel.tim0),
		.pwma_o(tim0_pwma_o), .pwmb_o(tim0_pwmb_o), .evt_o(tim0_evt),
		.rdat_o(rdat_tim0));

	mcoc_timer tim1 (.clk(clk), .rst_n_i(rst_n), .bus_i(bus_i), .sel_i(sel.tim1),
		.pwma_o(tim1_pwma_o), .pwmb_o(tim1_pwmb_o), .evt_o(tim1_evt),
		.rdat_o(rdat_tim1));

	mcoc_intc intc (.clk(clk), .rst_n_i(rst_n), .bus_i(bus_i), .sel_i(sel.intc),
		.int0_i(intc_int0_i), .int1_i(intc_int1_i), .tim0_evt_i(tim0_evt),
		.tim1_evt_i(tim1_evt), .irq_o(irq_o), .rdat_o(rdat_intc));

	// Pad drivers, floating unless enabled
	for (genvar i = 0; i < PW; i++) begin : g_pad
		assign port_io[i] = port_enb[i] ? port_out[i] : 1'bz;
	end

	// Idle blocks return zero so OR acts as read mux
	assign rdat_o = rdat_sysc | rdat_port | rdat_tim0 | rdat_tim1 | rdat_intc;

endmodule

`default_nettype wire

// File: tests/tb_mcoc.sv
`timescale 1ns/100ps
`default_nettype none
`include "mcoc_cfg.svh"

module tb_mcoc
	import mcoc_pkg::*;
();
	localparam int CLK_PER = 40;
	localparam int DIV = `MCOC_SYTM_DIV;
	localparam int TICK_K = 5;	// Ticks waited in tick test
	localparam int POLL_MAX = 64;	// Cycles to wait for irq_o

	// Cycle budget per test summed into watchdog limit
	localparam int RST_CYC = 8 + 4;
	localparam int T1_CYC = 12;
	localparam int T2_CYC = TICK_K * DIV + 4;
	localparam int T3_CYC = 20;
	localparam int T4_CYC = 2 * (8 + 41);
	localparam int T5_CYC = 60 + POLL_MAX;
	localparam int T6_CYC = 40;
	localparam int WD_CYC = RST_CYC + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC + 200;

	logic clk;
	logic arst_n_i;
	logic bootr_n_i;
	bus_req_t bus;
	logic [15:0] rdat_o;
	logic int0;
	logic int1;
	wire [15:0] port_io;
	logic tim0_pwma_o;
	logic tim0_pwmb_o;
	logic tim1_pwma_o;
	logic tim1_pwmb_o;
	logic irq_o;

	logic [15:0] pin_drv;	// Values the tb puts on pins
	logic [15:0] pin_en;	// Tb driver enables
	integer seed;
	int n_pass;
	int n_fail;

	mcoc_periph UUT (.clk(clk), .arst_n_i(arst_n_i), .bootr_n_i(bootr_n_i), .bus_i(bus),
		.rdat_o(rdat_o), .intc_int0_i(int0), .intc_int1_i(int1), .port_io(port_io),
		.tim0_pwma_o(tim0_pwma_o), .tim0_pwmb_o(tim0_pwmb_o), .tim1_pwma_o(tim1_pwma_o),
		.tim1_pwmb_o(tim1_pwmb_o), .irq_o(irq_o));

	// External pad drivers
	for (genvar i = 0; i < 16; i++) begin : g_pin
		assign port_io[i] = pin_en[i] ? pin_drv[i] : 1'bz;
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PER / 2) clk = ~clk;
	end

	function automatic logic [15:0] io_adr(input logic [3:0] blk, input logic [3:0] off);
		return {`MCOC_IO_PAGE, blk, off};
	endfunction

	task automatic wait_cycles(input int n);	// Ends 2 ns after an edge
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic bus_write(input logic [15:0] adr, input logic [15:0] data);
		bus.wr = 1'b1;
		bus.adr = adr;
		bus.wdat = data;
		wait_cycles(1);
		bus.wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] adr, output logic [15:0] data);
		bus.rd = 1'b1;
		bus.adr = adr;
		wait_cycles(1);
		bus.rd = 1'b0;
		data = rdat_o;	// Registered during strobe edge
	endtask

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			n_fail++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end else begin
			n_pass++;
		end
	endtask

	task automatic report_fail(input string what);
		n_fail++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	task automatic end_test(input string name, input int fail_start);
		$display("Test %s finished with %0d errors", name, n_fail - fail_start);
	endtask

	task automatic test_reset_id();
		logic [15:0] d;
		int f0;
		f0 = n_fail;
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_IDCODE), d);
		check("idcode", `MCOC_IDCODE, d);
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_VERSNO), d);
		check("versno", `MCOC_VERSNO, d);
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_FCPU), d);
		check("fcpu_khz", `MCOC_FCPU_KHZ, d);
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_BOOTMD), d);
		check("bootmd", {15'b0, ~bootr_n_i}, d);	// Latched inverse of pin
		check("port_io[7:0]", {8'h00, 8'hzz}, {8'h00, port_io[7:0]});
		check("pwm outputs", 16'h0,
			{12'b0, tim0_pwma_o, tim0_pwmb_o, tim1_pwma_o, tim1_pwmb_o});
		check("irq_o", 16'h0, {15'b0, irq_o});
		bus_read(io_adr(4'h5, 4'h0), d);	// Unused block number
		check("rdat_o unmapped block", 16'h0, d);
		bus_read(16'h0020, d);	// Outside I/O page
		check("rdat_o outside page", 16'h0, d);
		bus_read(io_adr(`MCOC_BLK_SYSC, 4'hA), d);	// Unused offset
		check("rdat_o unused offset", 16'h0, d);
		end_test("reset_id", f0);
	endtask

	task automatic test_tick();
		logic [15:0] t0;
		logic [15:0] t1;
		logic [15:0] dlt;
		int f0;
		f0 = n_fail;
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_TICK), t0);
		wait_cycles(TICK_K * DIV - 1);	// Strobes land TICK_K*DIV cycles apart
		bus_read(io_adr(`MCOC_BLK_SYSC, `MCOC_SYSC_TICK), t1);
		dlt = t1 - t0;
		check("tick delta", 16'(TICK_K), dlt);	// Whole prescaler periods between samples
		end_test("tick", f0);
	endtask

	task automatic test_port();
		logic [7:0] out;
		logic [7:0] enb;
		logic [7:0] psel;
		logic [7:0] exp_inp;
		logic own;
		logic [15:0] d;
		int f0;
		f0 = n_fail;
		out = $random(seed);
		enb = $random(seed);
		bus_write(io_adr(`MCOC_BLK_PORT, `MCOC_PORT_OUT), {8'h00, out});
		bus_write(io_adr(`MCOC_BLK_PORT, `MCOC_PORT_ENB), {8'h00, enb});
		wait_cycles(1);
		for (int i = 0; i < 8; i++)	// Driven where enabled, floating elsewhere
			check($sformatf("port_io[%0d]", i), {15'b0, enb[i] ? out[i] : 1'bz},
				{15'b0, port_io[i]});
		pin_drv = $random(seed);
		pin_en = {8'hFF, ~enb};	// Only pins the DUT leaves free
		psel = $random(seed);
		bus_write(io_adr(`MCOC_BLK_PORT, `MCOC_PORT_SEL), {8'h00, psel});
		wait_cycles(4);
		for (int i = 0; i < 8; i++) begin
			own = enb[i] ? out[i] : pin_drv[i];
			exp_inp[i] = psel[i] ? own : pin_drv[i + 8];	// Own pin or alternate
		end
		bus_read(io_adr(`MCOC_BLK_PORT, `MCOC_PORT_INP), d);
		check("port input", {8'h00, exp_inp}, d);
		bus_write(io_adr(`MCOC_BLK_PORT, `MCOC_PORT_ENB), 16'h0000);
		pin_en = 16'hFF00;
		end_test("port", f0);
	endtask

	task automatic test_pwm();
		logic [3:0] blk;
		logic [15:0] per;
		logic [15:0] cma;
		logic pa;
		logic pb;
		int na;
		int nb;
		int f0;
		f0 = n_fail;
		for (int t = 0; t < 2; t++) begin
			blk = (t == 0) ? `MCOC_BLK_TIM0 : `MCOC_BLK_TIM1;
			per = 16'd8 + 16'({$random(seed)} % 33);	// 8 to 40
			cma = 16'({$random(seed)} % (per + 1));	// 0 to period
			bus_write(io_adr(blk, `MCOC_TIM_PERIOD), per);
			bus_write(io_adr(blk, `MCOC_TIM_CMPA), cma);
			bus_write(io_adr(blk, `MCOC_TIM_CMPB), 16'h0000);
			bus_write(io_adr(blk, `MCOC_TIM_CTRL), 16'h0001);
			na = 0;
			nb = 0;
			for (int c = 0; c <= per; c++) begin	// One full period
				pa = (t == 0) ? tim0_pwma_o : tim1_pwma_o;
				pb = (t == 0) ? tim0_pwmb_o : tim1_pwmb_o;
				na += pa;
				nb += pb;
				wait_cycles(1);
			end
			check($sformatf("tim%0d pwma high cycles", t), cma, 16'(na));
			check($sformatf("tim%0d pwmb high cycles", t), 16'h0, 16'(nb));
			bus_write(io_adr(blk, `MCOC_TIM_CTRL), 16'h0000);
		end
		end_test("pwm", f0);
	endtask

	task automatic test_tim_irq();
		logic [15:0] d;
		int n;
		int f0;
		f0 = n_fail;
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_PERIOD), 16'd5);
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CMPA), 16'hFFFF);	// Never matched
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CMPB), 16'hFFFF);
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CNT), 16'h0000);
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), 16'h00FF);	// Drop old flags
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_ENB), 16'h0020);	// tim1 ovf only
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CTRL), 16'h0001);
		n = 0;
		while (!irq_o && n < POLL_MAX) begin
			wait_cycles(1);
			n++;
		end
		if (!irq_o)
			report_fail("irq_o did not rise with the tim1 overflow enabled");
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), d);
		check("intc flags", 16'h0020, d);
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_VEC), d);
		check("intc vector", 16'h0005, d);
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CTRL), 16'h0000);	// Stop before clear
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), 16'h0020);
		wait_cycles(1);
		check("irq_o after clear", 16'h0, {15'b0, irq_o});
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_VEC), d);
		check("intc vector idle", 16'h00FF, d);
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_ENB), 16'h0000);
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CTRL), 16'h0001);
		n = 0;
		for (int c = 0; c < 14; c++) begin	// Two periods and a bit
			n += irq_o;
			wait_cycles(1);
		end
		bus_write(io_adr(`MCOC_BLK_TIM1, `MCOC_TIM_CTRL), 16'h0000);
		check("irq_o high cycles masked", 16'h0, 16'(n + irq_o));
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), d);
		check("intc flag[5] masked", 16'h0001, {15'b0, d[5]});
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), 16'h00FF);
		end_test("tim_irq", f0);
	endtask

	task automatic test_ext_irq();
		logic [15:0] d;
		int w;
		int f0;
		f0 = n_fail;
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), 16'h00FF);
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_ENB), 16'h0003);	// int0 and int1
		w = {$random(seed)} % 4 + 1;
		int0 = 1'b1;
		wait_cycles(w);
		int0 = 1'b0;
		wait_cycles(4);
		w = {$random(seed)} % 4 + 1;
		int1 = 1'b1;
		wait_cycles(w);
		int1 = 1'b0;
		wait_cycles(4);	// Sync plus edge detect
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), d);
		check("intc flags", 16'h0003, d);
		check("irq_o", 16'h0001, {15'b0, irq_o});
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_VEC), d);
		check("intc vector", 16'h0000, d);	// Lowest index wins
		bus_write(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_FLAG), 16'h0001);
		bus_read(io_adr(`MCOC_BLK_INTC, `MCOC_INTC_VEC), d);
		check("intc vector after clear", 16'h0001, d);
		end_test("ext_irq", f0);
	endtask

	initial begin
		#(WD_CYC * CLK_PER);
		$display("Watchdog expired, the tests did not finish in %0d cycles", WD_CYC);
		$display("Something failed");
		$finish;
	end

	initial begin
		seed = 32'h4c91;
		n_pass = 0;
		n_fail = 0;
		arst_n_i = 1'b0;
		bootr_n_i = 1'b0;	// Boot mode 1
		bus = '0;
		int0 = 1'b0;
		int1 = 1'b0;
		pin_drv = 16'h0000;
		pin_en = 16'hFF00;	// Upper byte is input only
		repeat (8) @(posedge clk);
		#2;
		arst_n_i = 1'b1;
		wait_cycles(4);	// Synchronizer release
		test_reset_id();
		test_tick();
		test_port();
		test_pwm();
		test_tim_irq();
		test_ext_irq();
		$display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/mcoc_pkg.sv
rtl/mcoc_busdec.sv
rtl/mcoc_sysc.sv
rtl/mcoc_port.sv
rtl/mcoc_timer.sv
rtl/mcoc_intc.sv
rtl/mcoc_periph.sv
tests/tb_mcoc.sv

// File: Bender.yml
package:
  name: mcoc_periph

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mcoc_pkg.sv
      - rtl/mcoc_busdec.sv
      - rtl/mcoc_sysc.sv
      - rtl/mcoc_port.sv
      - rtl/mcoc_timer.sv
      - rtl/mcoc_intc.sv
      - rtl/mcoc_periph.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_mcoc.sv
